/* common/lsu_pkg.sv */
// Assumes a 32-bit address space with fixed DCCM and PIC windows; no DMA or fast-interrupt fields
package lsu_pkg;

   //**************************************************************************
   // Widths
   //**************************************************************************
   localparam int XLEN      = 32;
   localparam int OFFSET_W  = 12;          // Immediate offset of load/store
   localparam int MSCAUSE_W = 4;
   localparam int DCCM_HI_W = 16;          // Address bits compared for the DCCM window
   localparam int PIC_HI_W  = 17;          // Address bits compared for the PIC window

   //**************************************************************************
   // Memory map
   //**************************************************************************
   localparam logic [DCCM_HI_W-1:0] DCCM_BASE_HI = 16'hF004;   // 64 KB at F004_0000
   localparam logic [PIC_HI_W-1:0]  PIC_BASE_HI  = 17'h1E018;  // 32 KB at F00C_0000

   // Secondary cause reported with a load/store exception
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_NONE          = 4'h0;
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_ECC           = 4'h1;  // Double-bit ECC error
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_REGION_CROSS  = 4'h2;
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_PIC_SIZE      = 4'h3;  // PIC only takes aligned words
   localparam logic [MSCAUSE_W-1:0] MSCAUSE_EXT_UNALIGNED = 4'h4;

   //**************************************************************************
   // Types
   //**************************************************************************
   typedef enum logic [1:0] {
      LSU_BYTE = 2'd0,
      LSU_HALF = 2'd1,
      LSU_WORD = 2'd2
   } lsu_size_t;

   // Control packet; valid sits in the LSB so it can be split from the payload
   typedef struct packed {
      lsu_size_t size;
      logic      unsign;                     // Zero-extend byte and half loads
      logic      store;
      logic      load;
      logic      valid;
   } lsu_pkt_t;

   localparam int PKT_W = $bits(lsu_pkt_t);

   typedef struct packed {
      logic in_dccm;
      logic in_pic;
      logic external;                        // Neither DCCM nor PIC
   } lsu_region_t;

   typedef struct packed {
      logic                 access;          // Start and end in different regions
      logic                 misaligned;
      logic [MSCAUSE_W-1:0] mscause;
   } lsu_fault_t;

   typedef struct packed {
      logic                 exc_valid;
      logic                 single_ecc_error;
      logic                 inst_type;       // 1 for store
      logic                 exc_type;        // 0 misaligned, 1 access
      logic [MSCAUSE_W-1:0] mscause;
      logic [XLEN-1:0]      addr;
   } lsu_error_pkt_t;

endpackage

/* addr/lsu_addr_pipe.sv */
// Address and fault state advances every cycle without a stall; end address covers aligned spans only
module lsu_addr_pipe (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [lsu_pkg::XLEN-1:0]     exu_lsu_rs1_d,     // Base register
   input  logic [lsu_pkg::OFFSET_W-1:0] dec_lsu_offset_d,  // Signed immediate
   input  lsu_pkg::lsu_size_t           size_d,

   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_d,
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_m,
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_r,
   output lsu_pkg::lsu_region_t         region_d,
   output lsu_pkg::lsu_region_t         region_m,
   output lsu_pkg::lsu_region_t         region_r,
   output logic                         lsu_exc_m,         // Access or misaligned fault
   output lsu_pkg::lsu_fault_t          fault_r
);
   import lsu_pkg::*;

   logic [XLEN-1:0] offset_ext_d;
   logic [XLEN-1:0] end_offset_d;
   logic [XLEN-1:0] end_addr_d;
   lsu_region_t     end_region_d;
   logic            pic_misaligned_d;
   logic            ext_misaligned_d;
   lsu_fault_t      fault_d;
   lsu_fault_t      fault_m;

   // Classify an address against the DCCM and PIC windows
   function automatic lsu_region_t decode_region(input logic [XLEN-1:0] addr);
      lsu_region_t region;
      region.in_dccm  = (addr[XLEN-1 -: DCCM_HI_W] == DCCM_BASE_HI);
      region.in_pic   = (addr[XLEN-1 -: PIC_HI_W] == PIC_BASE_HI);
      region.external = ~(region.in_dccm | region.in_pic);
      return region;
   endfunction

   //**************************************************************************
   // D stage address generation
   //**************************************************************************
   assign offset_ext_d = {{(XLEN-OFFSET_W){dec_lsu_offset_d[OFFSET_W-1]}}, dec_lsu_offset_d};
   assign lsu_addr_d   = exu_lsu_rs1_d + offset_ext_d;

   // Last byte touched by the access
   always_comb begin
      case (size_d)
         LSU_BYTE: end_offset_d = '0;
         LSU_HALF: end_offset_d = XLEN'(1);
         default:  end_offset_d = XLEN'(3);
      endcase
   end

   assign end_addr_d   = lsu_addr_d + end_offset_d;
   assign region_d     = decode_region(lsu_addr_d);
   assign end_region_d = decode_region(end_addr_d);

   // PIC registers are word wide
   assign pic_misaligned_d = region_d.in_pic &
                             ((size_d != LSU_WORD) | (lsu_addr_d[1:0] != 2'b00));

   always_comb begin
      case (size_d)
         LSU_BYTE: ext_misaligned_d = 1'b0;
         LSU_HALF: ext_misaligned_d = region_d.external & lsu_addr_d[0];
         default:  ext_misaligned_d = region_d.external & (lsu_addr_d[1:0] != 2'b00);
      endcase
   end

   // Access fault takes priority over misalignment
   always_comb begin
      fault_d.access     = (region_d != end_region_d);
      fault_d.misaligned = ~fault_d.access & (pic_misaligned_d | ext_misaligned_d);
      if (fault_d.access) begin
         fault_d.mscause = MSCAUSE_REGION_CROSS;
      end else if (pic_misaligned_d) begin
         fault_d.mscause = MSCAUSE_PIC_SIZE;
      end else if (ext_misaligned_d) begin
         fault_d.mscause = MSCAUSE_EXT_UNALIGNED;
      end else begin
         fault_d.mscause = MSCAUSE_NONE;
      end
   end

   //**************************************************************************
   // M and R staging
   //**************************************************************************
   always_ff @(posedge clk) begin
      lsu_addr_m <= lsu_addr_d;
      lsu_addr_r <= lsu_addr_m;
      region_m   <= region_d;
      region_r   <= region_m;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fault_m <= '0;
         fault_r <= '0;
      end else begin
         fault_m <= fault_d;
         fault_r <= fault_m;
      end
   end

   assign lsu_exc_m = fault_m.access | fault_m.misaligned;   // To the trap logic in M

endmodule

/* rtl/lsu_pkt_pipe.sv */
// Packet advances every cycle; flush_m_up kills both the D-to-M and M-to-R transfers
module lsu_pkt_pipe (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::lsu_pkt_t lsu_p,          // Decoded packet in D
   input  logic              flush_m_up,     // Flush of M and older stages

   output lsu_pkg::lsu_pkt_t lsu_pkt_m,
   output lsu_pkg::lsu_pkt_t lsu_pkt_r
);
   import lsu_pkg::*;

   logic             valid_m;
   logic             valid_r;
   logic [PKT_W-1:1] pkt_hi_m;               // Packet without valid
   logic [PKT_W-1:1] pkt_hi_r;

   //**************************************************************************
   // Valid bits, kept in reset flops
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_m <= 1'b0;
         valid_r <= 1'b0;
      end else begin
         valid_m <= lsu_p.valid & ~flush_m_up;
         valid_r <= valid_m & ~flush_m_up;
      end
   end

   // Payload fields follow the valid bit
   always_ff @(posedge clk) begin
      pkt_hi_m <= lsu_p[PKT_W-1:1];
      pkt_hi_r <= pkt_hi_m;
   end

   assign lsu_pkt_m = {pkt_hi_m, valid_m};
   assign lsu_pkt_r = {pkt_hi_r, valid_r};

endmodule

/* rtl/lsu_result_stage.sv */
// R-stage outputs are combinational from R inputs; bus data is captured in M only for external accesses
module lsu_result_stage (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lsu_pkg::lsu_pkt_t        lsu_pkt_r,
   input  lsu_pkg::lsu_region_t     region_m,
   input  lsu_pkg::lsu_region_t     region_r,
   input  lsu_pkg::lsu_fault_t      fault_r,
   input  logic [lsu_pkg::XLEN-1:0] lsu_addr_r,
   input  logic [lsu_pkg::XLEN-1:0] bus_read_data_m,         // Bus return data in M
   input  logic [lsu_pkg::XLEN-1:0] lsu_ld_data_corr_r,      // ECC corrected DCCM/PIC data
   input  logic                     lsu_single_ecc_error_r,
   input  logic                     lsu_double_ecc_error_r,
   input  logic                     flush_r,

   output logic [lsu_pkg::XLEN-1:0] lsu_result_corr_r,       // Load data to the register file
   output lsu_pkg::lsu_error_pkt_t  lsu_error_pkt_r,
   output logic                     lsu_commit_r,
   output logic                     lsu_single_ecc_error_incr
);
   import lsu_pkg::*;

   logic [XLEN-1:0] bus_read_data_r;
   logic [XLEN-1:0] ld_data_r;
   logic            exc_valid_r;

   //**************************************************************************
   // Load data
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bus_read_data_r <= '0;
      end else if (region_m.external) begin
         bus_read_data_r <= bus_read_data_m;
      end
   end

   assign ld_data_r = region_r.external ? bus_read_data_r : lsu_ld_data_corr_r;

   // Extend byte and half by sign or zero
   always_comb begin
      case (lsu_pkt_r.size)
         LSU_BYTE: begin
            lsu_result_corr_r = lsu_pkt_r.unsign ?
                                {{(XLEN-8){1'b0}}, ld_data_r[7:0]} :
                                {{(XLEN-8){ld_data_r[7]}}, ld_data_r[7:0]};
         end
         LSU_HALF: begin
            lsu_result_corr_r = lsu_pkt_r.unsign ?
                                {{(XLEN-16){1'b0}}, ld_data_r[15:0]} :
                                {{(XLEN-16){ld_data_r[15]}}, ld_data_r[15:0]};
         end
         default: lsu_result_corr_r = ld_data_r;              // Word
      endcase
   end

   //**************************************************************************
   // Exception packet and commit
   //**************************************************************************
   assign exc_valid_r = lsu_pkt_r.valid &
                        (fault_r.access | fault_r.misaligned | lsu_double_ecc_error_r);

   always_comb begin
      lsu_error_pkt_r.exc_valid        = exc_valid_r;
      lsu_error_pkt_r.single_ecc_error = lsu_single_ecc_error_r & ~exc_valid_r;
      lsu_error_pkt_r.inst_type        = lsu_pkt_r.store;
      lsu_error_pkt_r.exc_type         = ~fault_r.misaligned;
      // ECC cause only when no address fault is present
      if (lsu_double_ecc_error_r & ~fault_r.access & ~fault_r.misaligned) begin
         lsu_error_pkt_r.mscause = MSCAUSE_ECC;
      end else begin
         lsu_error_pkt_r.mscause = fault_r.mscause;
      end
      lsu_error_pkt_r.addr = lsu_addr_r;
   end

   assign lsu_commit_r = lsu_pkt_r.valid & ~flush_r & (lsu_pkt_r.load | lsu_pkt_r.store);

   // Counts corrected errors of committed accesses
   assign lsu_single_ecc_error_incr = lsu_single_ecc_error_r & ~lsu_double_ecc_error_r &
                                      lsu_commit_r;

endmodule

/* rtl/lsu_ctl.sv */
// Load/store control with a D/M/R pipe and no back-pressure; no DMA, bypass or store data path
module lsu_ctl (
   input  logic                         clk,
   input  logic                         rst_n,

   // D stage
   input  lsu_pkg::lsu_pkt_t            lsu_p,
   input  logic [lsu_pkg::XLEN-1:0]     exu_lsu_rs1_d,
   input  logic [lsu_pkg::OFFSET_W-1:0] dec_lsu_offset_d,

   // Flushes
   input  logic                         flush_m_up,
   input  logic                         flush_r,

   // Memory and bus returns
   input  logic [lsu_pkg::XLEN-1:0]     lsu_ld_data_corr_r,
   input  logic                         lsu_single_ecc_error_r,
   input  logic                         lsu_double_ecc_error_r,
   input  logic [lsu_pkg::XLEN-1:0]     bus_read_data_m,

   // Address and region per stage
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_d,
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_m,
   output logic [lsu_pkg::XLEN-1:0]     lsu_addr_r,
   output lsu_pkg::lsu_region_t         region_d,
   output lsu_pkg::lsu_region_t         region_m,
   output lsu_pkg::lsu_region_t         region_r,
   output logic                         lsu_exc_m,

   // Packet per stage
   output lsu_pkg::lsu_pkt_t            lsu_pkt_m,
   output lsu_pkg::lsu_pkt_t            lsu_pkt_r,

   // R stage results
   output logic [lsu_pkg::XLEN-1:0]     lsu_result_corr_r,
   output lsu_pkg::lsu_error_pkt_t      lsu_error_pkt_r,
   output logic                         lsu_commit_r,
   output logic                         lsu_single_ecc_error_incr
);
   import lsu_pkg::*;

   lsu_fault_t fault_r;                      // Staged fault set for the error packet

   lsu_addr_pipe u_addr (
      .clk              (clk),
      .rst_n            (rst_n),
      .exu_lsu_rs1_d    (exu_lsu_rs1_d),
      .dec_lsu_offset_d (dec_lsu_offset_d),
      .size_d           (lsu_p.size),
      .lsu_addr_d       (lsu_addr_d),
      .lsu_addr_m       (lsu_addr_m),
      .lsu_addr_r       (lsu_addr_r),
      .region_d         (region_d),
      .region_m         (region_m),
      .region_r         (region_r),
      .lsu_exc_m        (lsu_exc_m),
      .fault_r          (fault_r)
   );

   lsu_pkt_pipe u_pkt (
      .clk        (clk),
      .rst_n      (rst_n),
      .lsu_p      (lsu_p),
      .flush_m_up (flush_m_up),
      .lsu_pkt_m  (lsu_pkt_m),
      .lsu_pkt_r  (lsu_pkt_r)
   );

   lsu_result_stage u_result (
      .clk                       (clk),
      .rst_n                     (rst_n),
      .lsu_pkt_r                 (lsu_pkt_r),
      .region_m                  (region_m),
      .region_r                  (region_r),
      .fault_r                   (fault_r),
      .lsu_addr_r                (lsu_addr_r),
      .bus_read_data_m           (bus_read_data_m),
      .lsu_ld_data_corr_r        (lsu_ld_data_corr_r),
      .lsu_single_ecc_error_r    (lsu_single_ecc_error_r),
      .lsu_double_ecc_error_r    (lsu_double_ecc_error_r),
      .flush_r                   (flush_r),
      .lsu_result_corr_r         (lsu_result_corr_r),
      .lsu_error_pkt_r           (lsu_error_pkt_r),
      .lsu_commit_r              (lsu_commit_r),
      .lsu_single_ecc_error_incr (lsu_single_ecc_error_incr)
   );

endmodule

/* sim/tb_clock.sv */
// Free-running clock of period 8 with rst_n held low for the first 3 rising edges
module tb_clock (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 3;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;                         // Release on a rising edge
   end

endmodule

/* sim/lsu_ctl_assertions.sv */
// Bound to lsu_ctl; checks commit, error packet and reset invariants on every rising clock edge
module lsu_ctl_assertions (
   input logic                    clk,
   input logic                    rst_n,
   input lsu_pkg::lsu_pkt_t       lsu_pkt_r,
   input lsu_pkg::lsu_error_pkt_t lsu_error_pkt_r,
   input logic                    lsu_commit_r
);

   // A commit needs a live R packet
   commit_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_commit_r |-> lsu_pkt_r.valid)
      else $error("lsu_commit_r without a valid R-stage packet");

   // Corrected error is only reported when no exception is taken
   exc_or_single_ecc: assert property (@(posedge clk) disable iff (!rst_n)
      !(lsu_error_pkt_r.exc_valid && lsu_error_pkt_r.single_ecc_error))
      else $error("exc_valid and single_ecc_error set together");

   no_commit_in_reset: assert property (@(posedge clk)
      !rst_n |-> !lsu_commit_r)
      else $error("lsu_commit_r raised while in reset");

endmodule

bind lsu_ctl lsu_ctl_assertions u_lsu_ctl_assertions (
   .clk             (clk),
   .rst_n           (rst_n),
   .lsu_pkt_r       (lsu_pkt_r),
   .lsu_error_pkt_r (lsu_error_pkt_r),
   .lsu_commit_r    (lsu_commit_r)
);

/* sim/tb_lsu_ctl.sv */
// Random accesses over DCCM, PIC, external and window edges; first mismatch ends the run
module tb_lsu_ctl;
   import lsu_pkg::*;

   localparam int N_TESTS = 400;

   // One D-stage access with the M and R inputs driven in the same cycle
   typedef struct packed {
      logic                live;
      lsu_pkt_t            pkt;
      logic [XLEN-1:0]     rs1;
      logic [OFFSET_W-1:0] off;
      logic                flush_m_up;
      logic                flush_r;
      logic [XLEN-1:0]     ld_data;
      logic [XLEN-1:0]     bus;
      logic                sec;
      logic                dbl;
   } stim_t;

   logic clk, rst_n;
   lsu_pkt_t lsu_p, lsu_pkt_m, lsu_pkt_r;
   logic [XLEN-1:0] exu_lsu_rs1_d, lsu_ld_data_corr_r, bus_read_data_m;
   logic [OFFSET_W-1:0] dec_lsu_offset_d;
   logic flush_m_up, flush_r, lsu_single_ecc_error_r, lsu_double_ecc_error_r;
   logic [XLEN-1:0] lsu_addr_d, lsu_addr_m, lsu_addr_r, lsu_result_corr_r;
   lsu_region_t region_d, region_m, region_r;
   logic lsu_exc_m, lsu_commit_r, lsu_single_ecc_error_incr;
   lsu_error_pkt_t lsu_error_pkt_r;

   stim_t       hist [3];                     // 0 in D, 1 in M, 2 in R
   logic [31:0] rng = 32'd65302;
   logic [XLEN-1:0] bus_q = '0;               // Model of the captured bus data

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   lsu_ctl uut (.*);

   //**************************************************************************
   // Reference model
   //**************************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [XLEN-1:0] effective_addr(input stim_t s);
      return s.rs1 + {{(XLEN-OFFSET_W){s.off[OFFSET_W-1]}}, s.off};
   endfunction

   function automatic lsu_region_t classify_region(input logic [XLEN-1:0] a);
      lsu_region_t r;
      r.in_dccm  = (a[31:16] == DCCM_BASE_HI);
      r.in_pic   = (a[31:15] == PIC_BASE_HI);
      r.external = !r.in_dccm && !r.in_pic;
      return r;
   endfunction

   function automatic lsu_fault_t expect_fault(input logic [XLEN-1:0] a, input lsu_size_t sz);
      lsu_fault_t  f;
      lsu_region_t rs;
      logic        pic_bad, ext_bad;
      logic [XLEN-1:0] last;
      last    = a + ((sz == LSU_BYTE) ? 32'd0 : (sz == LSU_HALF) ? 32'd1 : 32'd3);
      rs      = classify_region(a);
      pic_bad = rs.in_pic && (sz != LSU_WORD || a[1:0] != 2'b00);
      ext_bad = rs.external && ((sz == LSU_HALF && a[0]) || (sz == LSU_WORD && a[1:0] != 2'b00));
      f.access     = (rs != classify_region(last));
      f.misaligned = !f.access && (pic_bad || ext_bad);
      f.mscause    = f.access ? MSCAUSE_REGION_CROSS : pic_bad ? MSCAUSE_PIC_SIZE :
                     ext_bad ? MSCAUSE_EXT_UNALIGNED : MSCAUSE_NONE;
      return f;
   endfunction

   function automatic logic [XLEN-1:0] format_load(input logic [XLEN-1:0] d, input lsu_pkt_t p);
      if (p.size == LSU_BYTE) return p.unsign ? {24'b0, d[7:0]} : {{24{d[7]}}, d[7:0]};
      if (p.size == LSU_HALF) return p.unsign ? {16'b0, d[15:0]} : {{16{d[15]}}, d[15:0]};
      return d;
   endfunction

   function automatic lsu_error_pkt_t expect_error_pkt(input lsu_fault_t f, input lsu_pkt_t p,
                                                       input logic sec, input logic dbl,
                                                       input logic [XLEN-1:0] a);
      lsu_error_pkt_t e;
      e.exc_valid        = p.valid && (f.access || f.misaligned || dbl);
      e.single_ecc_error = sec && !e.exc_valid;
      e.inst_type        = p.store;
      e.exc_type         = !f.misaligned;    // Access and ECC both report as access
      e.mscause          = (dbl && !f.access && !f.misaligned) ? MSCAUSE_ECC : f.mscause;
      e.addr             = a;
      return e;
   endfunction

   //**************************************************************************
   // Compare tasks
   //**************************************************************************
   task automatic abort_run(input string why);
      $display("Verification failed");
      $fatal(1, "%s", why);
   endtask

   task automatic check_addr(input string what, input logic [XLEN-1:0] got, exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run("data mismatch");
      end
   endtask

   task automatic check_region(input string what, input lsu_region_t got, exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run("region mismatch");
      end
   endtask

   task automatic check_pkt(input string what, input lsu_pkt_t got, exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run("packet mismatch");
      end
   endtask

   task automatic check_error_pkt(input string what, input lsu_error_pkt_t got, exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
         abort_run("error packet mismatch");
      end
   endtask

   task automatic check_bit(input string what, input logic got, exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run("control bit mismatch");
      end
   endtask

   //**************************************************************************
   // Stimulus
   //**************************************************************************
   task automatic drive_access(input logic live);
      stim_t       s;
      logic [31:0] r, q;
      rng = xorshift32(rng);
      r   = rng;
      rng = xorshift32(rng);
      q   = rng;
      s   = '0;
      if (live) begin
         case (r[1:0])
            2'd0:    s.rs1 = {DCCM_BASE_HI, q[15:0]};
            2'd1:    s.rs1 = {PIC_BASE_HI, q[14:0]};
            2'd2:    s.rs1 = q;
            default: s.rs1 = (r[2] ? 32'hF004_FFFC : 32'hF00C_7FFC) + {30'b0, q[1:0]};
         endcase
         s.off = (r[1:0] == 2'd3) ? {10'b0, r[4:3]} : r[31:20];   // Small step near edges
         s.live        = 1'b1;
         s.pkt.size    = (r[6:5] == 2'b11) ? LSU_WORD : lsu_size_t'(r[6:5]);
         s.pkt.valid   = (r[9:7] != 3'd0);
         s.pkt.load    = r[10];
         s.pkt.store   = !r[10] && r[11];
         s.pkt.unsign  = r[12];
         s.flush_m_up  = (r[16:13] == 4'd0);
         s.flush_r     = (r[19:17] == 3'd0);
         s.sec         = (q[31:29] == 3'd0);
         s.dbl         = (q[28:26] == 3'd0);
         rng = xorshift32(rng);
         s.ld_data = rng;
         rng = xorshift32(rng);
         s.bus = rng;
      end
      lsu_p                  <= s.pkt;
      exu_lsu_rs1_d          <= s.rs1;
      dec_lsu_offset_d       <= s.off;
      flush_m_up             <= s.flush_m_up;
      flush_r                <= s.flush_r;
      lsu_ld_data_corr_r     <= s.ld_data;
      bus_read_data_m        <= s.bus;
      lsu_single_ecc_error_r <= s.sec;
      lsu_double_ecc_error_r <= s.dbl;
      hist[2] = hist[1];
      hist[1] = hist[0];
      hist[0] = s;
   endtask

   initial begin
      hist = '{default: '0};
      drive_access(1'b0);                     // All inputs idle at time 0
      wait (rst_n);
      repeat (N_TESTS) begin
         @(posedge clk);
         drive_access(1'b1);
      end
      repeat (3) begin
         @(posedge clk);
         drive_access(1'b0);                  // Drain M and R
      end
      @(posedge clk);
      $display("Verification passed");
      $finish;
   end

   initial begin
      #(N_TESTS * 8 * 4);
      $display("Timeout at %0t, the run did not reach its end", $time);
      abort_run("watchdog expired");
   end

   //**************************************************************************
   // Compare at the falling edge, where every output is settled
   //**************************************************************************
   initial begin : compare
      logic [XLEN-1:0] a0, a1, a2;
      lsu_region_t     rg1, rg2;
      lsu_fault_t      f1, f2;
      lsu_pkt_t        pm, pr;
      logic            commit;
      @(negedge clk);
      while (!rst_n) begin
         check_bit("lsu_pkt_m.valid in reset", lsu_pkt_m.valid, 1'b0);
         check_bit("lsu_pkt_r.valid in reset", lsu_pkt_r.valid, 1'b0);
         check_bit("lsu_commit_r in reset", lsu_commit_r, 1'b0);
         check_bit("ecc incr in reset", lsu_single_ecc_error_incr, 1'b0);
         check_bit("exc_valid in reset", lsu_error_pkt_r.exc_valid, 1'b0);
         @(negedge clk);
      end
      forever begin
         a0 = effective_addr(hist[0]);
         a1 = effective_addr(hist[1]);
         a2 = effective_addr(hist[2]);
         rg1 = classify_region(a1);
         rg2 = classify_region(a2);
         f1 = expect_fault(a1, hist[1].pkt.size);
         f2 = expect_fault(a2, hist[2].pkt.size);
         pm = hist[1].pkt;
         pm.valid = hist[1].pkt.valid && !hist[1].flush_m_up;
         pr = hist[2].pkt;
         pr.valid = hist[2].pkt.valid && !hist[2].flush_m_up && !hist[1].flush_m_up;
         if (hist[0].live) begin
            check_addr("lsu_addr_d", lsu_addr_d, a0);
            check_region("region_d", region_d, classify_region(a0));
         end
         if (hist[1].live) begin
            check_addr("lsu_addr_m", lsu_addr_m, a1);
            check_region("region_m", region_m, rg1);
            check_bit("lsu_exc_m", lsu_exc_m, f1.access || f1.misaligned);
            check_pkt("lsu_pkt_m", lsu_pkt_m, pm);
         end else begin
            check_bit("lsu_pkt_m.valid", lsu_pkt_m.valid, pm.valid);
         end
         if (hist[2].live) begin
            check_addr("lsu_addr_r", lsu_addr_r, a2);
            check_region("region_r", region_r, rg2);
            check_pkt("lsu_pkt_r", lsu_pkt_r, pr);
            check_addr("lsu_result_corr_r", lsu_result_corr_r,
                       format_load(rg2.external ? bus_q : hist[0].ld_data, pr));
            check_error_pkt("lsu_error_pkt_r", lsu_error_pkt_r,
                            expect_error_pkt(f2, pr, hist[0].sec, hist[0].dbl, a2));
         end else begin
            check_bit("lsu_pkt_r.valid", lsu_pkt_r.valid, pr.valid);
            check_bit("exc_valid", lsu_error_pkt_r.exc_valid, 1'b0);
         end
         commit = pr.valid && !hist[0].flush_r && (pr.load || pr.store);
         check_bit("lsu_commit_r", lsu_commit_r, commit);
         check_bit("lsu_single_ecc_error_incr", lsu_single_ecc_error_incr,
                   hist[0].sec && !hist[0].dbl && commit);
         // Bus data is taken at the next edge when the M access is external
         if (rg1.external) bus_q = hist[0].bus;
         @(negedge clk);
      end
   end

endmodule

/* verilog.f */
common/lsu_pkg.sv
addr/lsu_addr_pipe.sv
rtl/lsu_pkt_pipe.sv
rtl/lsu_result_stage.sv
rtl/lsu_ctl.sv
sim/tb_clock.sv
sim/lsu_ctl_assertions.sv
sim/tb_lsu_ctl.sv

/* Makefile */
TOP = tb_lsu_ctl
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
